//--- list.f
hw/sink_pkg.sv
hw/sink_addrgen.sv
hw/sink_addr_fifo.sv
hw/sink_streamer.sv
hw/sink_regs_axil.sv
hw/sink_top.sv
verification/sink_tb.sv

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator and run it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module sink_tb -f list.f -o sink_sim

out=$(./obj_dir/sink_sim)
printf '%s\n' "$out"

# The run counts as passed only if the pass line was printed
printf '%s\n' "$out" | grep -qx 'all tests passed'

//--- verification/sink_tb.sv
`timescale 1ns/100ps
`default_nettype none

module sink_tb;

  localparam int unsigned DATA_WIDTH  = 64;
  localparam int unsigned BEAT_W      = DATA_WIDTH - 32;
  localparam int unsigned STRB_W      = DATA_WIDTH / 8;
  localparam int unsigned BEAT_STRB_W = BEAT_W / 8;
  localparam int unsigned CLK_PERIOD  = 100;
  localparam int unsigned SEED        = 49733;
  // Beats of every job in the run, each allowed 60 cycles, plus room for register traffic
  localparam int unsigned TOTAL_BEATS = 6 + 3 * 5 + 20 + 3 + 6;
  localparam int unsigned WATCHDOG_NS = (TOTAL_BEATS * 60 + 1000) * CLK_PERIOD;

  logic                    clk_i;
  logic                    rst_ni;
  sink_pkg::addr_t         awaddr_i;
  logic                    awvalid_i;
  logic                    awready_o;
  logic [31:0]             wdata_i;
  logic [3:0]              wstrb_i;
  logic                    wvalid_i;
  logic                    wready_o;
  logic [1:0]              bresp_o;
  logic                    bvalid_o;
  logic                    bready_i;
  sink_pkg::addr_t         araddr_i;
  logic                    arvalid_i;
  logic                    arready_o;
  logic [31:0]             rdata_o;
  logic [1:0]              rresp_o;
  logic                    rvalid_o;
  logic                    rready_i;
  logic                    stream_valid_i;
  logic                    stream_ready_o;
  logic [BEAT_W-1:0]       stream_data_i;
  logic [BEAT_STRB_W-1:0]  stream_strb_i;
  logic                    mem_req_o;
  logic                    mem_gnt_i;
  sink_pkg::addr_t         mem_addr_o;
  logic [STRB_W-1:0]       mem_be_o;
  logic [DATA_WIDTH-1:0]   mem_data_o;
  logic                    done_o;

  int unsigned gnt_pct = 100; // Chance of grant per cycle, in percent
  int unsigned gap_pct = 0;   // Chance of an idle cycle before each beat
  int          checks = 0;
  int          errors = 0;

  // Everything the memory model saw, in order of the write handshakes
  sink_pkg::addr_t       wr_addr_q[$];
  logic [STRB_W-1:0]     wr_be_q[$];
  logic [DATA_WIDTH-1:0] wr_data_q[$];
  logic [BEAT_W-1:0]     sent_q[$];
  int                    cycle = 0;
  int                    last_wr_cycle = 0;
  int                    done_cycle = 0;
  int                    done_count = 0;
  int                    hold_checks = 0;
  int                    hold_errors = 0;
  logic                  held = 1'b0;
  sink_pkg::addr_t       held_addr;
  logic [STRB_W-1:0]     held_be;
  logic [DATA_WIDTH-1:0] held_data;

  sink_top #(
    .DATA_WIDTH ( DATA_WIDTH )
  ) DUT (
    .clk_i, .rst_ni,
    .awaddr_i, .awvalid_i, .awready_o, .wdata_i, .wstrb_i, .wvalid_i, .wready_o,
    .bresp_o, .bvalid_o, .bready_i,
    .araddr_i, .arvalid_i, .arready_o, .rdata_o, .rresp_o, .rvalid_o, .rready_i,
    .stream_valid_i, .stream_ready_o, .stream_data_i, .stream_strb_i,
    .mem_req_o, .mem_gnt_i, .mem_addr_o, .mem_be_o, .mem_data_o,
    .done_o
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // Random grant from the memory side
  initial begin
    mem_gnt_i = 1'b0;
    forever begin
      @(negedge clk_i);
      mem_gnt_i = ($urandom_range(99) < gnt_pct);
    end
  end

  // Memory model, also watches that a waiting request holds still
  always @(posedge clk_i) begin
    if (rst_ni) begin
      cycle++;
      if (held) begin
        hold_checks++;
        assert (mem_req_o && mem_addr_o == held_addr && mem_be_o == held_be &&
                mem_data_o == held_data)
        else begin
          hold_errors++;
          $display("** Error at %0t ns: memory request changed while waiting for grant",
                   $time);
        end
      end
      held      = mem_req_o && !mem_gnt_i;
      held_addr = mem_addr_o;
      held_be   = mem_be_o;
      held_data = mem_data_o;
      if (mem_req_o && mem_gnt_i) begin
        wr_addr_q.push_back(mem_addr_o);
        wr_be_q.push_back(mem_be_o);
        wr_data_q.push_back(mem_data_o);
        last_wr_cycle = cycle;
      end
      if (done_o) begin
        done_count++;
        done_cycle = cycle;
      end
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
    $display("tests failed");
    $finish;
  end

  task automatic check_equal(input logic [63:0] got, input logic [63:0] exp,
                             input string what);
    checks++;
    assert (got == exp)
    else begin
      errors++;
      $display("** Error at %0t ns: %s, got 0x%0h, expected 0x%0h", $time, what, got, exp);
    end
  endtask

  task automatic write_reg(input logic [31:0] addr, input logic [31:0] data,
                           input logic [3:0] strb);
    @(negedge clk_i);
    awaddr_i  = addr;
    wdata_i   = data;
    wstrb_i   = strb;
    awvalid_i = 1'b1;
    wvalid_i  = 1'b1;
    bready_i  = 1'b1;
    do @(posedge clk_i); while (!(awready_o && wready_o));
    @(negedge clk_i);
    awvalid_i = 1'b0;
    wvalid_i  = 1'b0;
    do @(posedge clk_i); while (!bvalid_o);
    check_equal(64'(bresp_o), 64'(0), "write response");
    @(negedge clk_i);
    bready_i = 1'b0;
  endtask

  task automatic read_reg(input logic [31:0] addr, output logic [31:0] data);
    @(negedge clk_i);
    araddr_i  = addr;
    arvalid_i = 1'b1;
    rready_i  = 1'b1;
    do @(posedge clk_i); while (!arready_o);
    @(negedge clk_i);
    arvalid_i = 1'b0;
    do @(posedge clk_i); while (!rvalid_o);
    data = rdata_o;
    check_equal(64'(rresp_o), 64'(0), "read response");
    @(negedge clk_i);
    rready_i = 1'b0;
  endtask

  task automatic send_beats(input int unsigned n);
    logic [BEAT_W-1:0] beat;
    for (int unsigned i = 0; i < n; i++) begin
      @(negedge clk_i);
      stream_valid_i = 1'b0;
      while ($urandom_range(99) < gap_pct) @(negedge clk_i);
      beat = BEAT_W'($urandom());
      sent_q.push_back(beat);
      stream_data_i  = beat;
      stream_strb_i  = '1;
      stream_valid_i = 1'b1;
      do @(posedge clk_i); while (!stream_ready_o); // Beat moves on valid and ready
    end
    @(negedge clk_i);
    stream_valid_i = 1'b0;
    stream_strb_i  = '0;
  endtask

  task automatic run_job(input logic [31:0] base, input logic [31:0] stride,
                         input int unsigned len);
    int unsigned           first_wr;
    int unsigned           first_beat;
    int                    done_before;
    logic [31:0]           rd;
    logic [31:0]           addr;
    logic [1:0]            off;
    logic [STRB_W-1:0]     exp_be;
    logic [DATA_WIDTH-1:0] exp_data;
    first_wr    = wr_addr_q.size();
    first_beat  = sent_q.size();
    done_before = done_count;
    write_reg(sink_pkg::REG_BASE, base, 4'hF);
    write_reg(sink_pkg::REG_STRIDE, stride, 4'hF);
    write_reg(sink_pkg::REG_LEN, len, 4'hF);
    write_reg(sink_pkg::REG_CTRL, 32'h1, 4'h1);
    read_reg(sink_pkg::REG_STATUS, rd);
    check_equal(64'(rd), 64'(0), "STATUS while busy");
    send_beats(len);
    while (done_count == done_before) @(negedge clk_i);
    repeat (4) @(negedge clk_i);
    check_equal(64'(done_count - done_before), 64'(1), "done pulses for one job");
    check_equal(64'(done_cycle), 64'(last_wr_cycle + 2), "cycle of done after last write");
    check_equal(64'(wr_addr_q.size() - first_wr), 64'(len), "writes in job");
    for (int unsigned i = 0; i < len && first_wr + i < wr_addr_q.size(); i++) begin
      addr     = base + stride * i;
      off      = addr[1:0];
      exp_be   = STRB_W'({BEAT_STRB_W{1'b1}}) << off;
      exp_data = DATA_WIDTH'(sent_q[first_beat + i]) << (8 * off);
      check_equal(64'(wr_addr_q[first_wr + i]), 64'({addr[31:2], 2'b00}), "write address");
      check_equal(64'(wr_be_q[first_wr + i]), 64'(exp_be), "write byte enables");
      check_equal(64'(wr_data_q[first_wr + i]), 64'(exp_data), "write data");
    end
    read_reg(sink_pkg::REG_STATUS, rd);
    check_equal(64'(rd), 64'(3), "STATUS after job");
  endtask

  // Three of ten beats go out, then the job is cleared
  task automatic clear_mid_job();
    int unsigned first_wr;
    int          done_before;
    logic [31:0] rd;
    first_wr    = wr_addr_q.size();
    done_before = done_count;
    write_reg(sink_pkg::REG_BASE, 32'h0000_3000, 4'hF);
    write_reg(sink_pkg::REG_STRIDE, 32'd4, 4'hF);
    write_reg(sink_pkg::REG_LEN, 32'd10, 4'hF);
    write_reg(sink_pkg::REG_CTRL, 32'h1, 4'h1);
    send_beats(3);
    write_reg(sink_pkg::REG_CTRL, 32'h2, 4'h1);
    // A beat offered after the clear finds no queued address and must not reach memory
    stream_data_i  = BEAT_W'($urandom());
    stream_strb_i  = '1;
    stream_valid_i = 1'b1;
    repeat (20) begin
      @(posedge clk_i);
      check_equal(64'(stream_ready_o), 64'(0), "stream ready after clear");
    end
    @(negedge clk_i);
    stream_valid_i = 1'b0;
    stream_strb_i  = '0;
    check_equal(64'(wr_addr_q.size() - first_wr), 64'(3), "writes around clear");
    check_equal(64'(done_count - done_before), 64'(0), "done pulses after clear");
    read_reg(sink_pkg::REG_STATUS, rd);
    check_equal(64'(rd), 64'(1), "STATUS after clear");
  endtask

  initial begin
    logic [31:0] rd;
    rst_ni         = 1'b0;
    awaddr_i       = '0;
    awvalid_i      = 1'b0;
    wdata_i        = '0;
    wstrb_i        = '0;
    wvalid_i       = 1'b0;
    bready_i       = 1'b0;
    araddr_i       = '0;
    arvalid_i      = 1'b0;
    rready_i       = 1'b0;
    stream_valid_i = 1'b0;
    stream_data_i  = '0;
    stream_strb_i  = '0;
    void'($urandom(SEED));
    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);

    check_equal(64'({mem_req_o, done_o}), 64'(0), "mem_req_o and done_o after reset");
    check_equal(64'({awready_o, wready_o, arready_o, bvalid_o, rvalid_o}), 64'(0),
                "AXI4-Lite handshakes after reset");
    read_reg(sink_pkg::REG_STATUS, rd);
    check_equal(64'(rd), 64'(1), "STATUS after reset");

    // Partial writes only touch the bytes whose strobe is set
    write_reg(sink_pkg::REG_BASE, 32'h1234_5678, 4'hF);
    read_reg(sink_pkg::REG_BASE, rd);
    check_equal(64'(rd), 64'h1234_5678, "BASE readback");
    write_reg(sink_pkg::REG_BASE, 32'hAABB_CCDD, 4'b0101);
    read_reg(sink_pkg::REG_BASE, rd);
    check_equal(64'(rd), 64'h12BB_56DD, "BASE after partial write");
    write_reg(sink_pkg::REG_STRIDE, 32'hA5A5_A5A5, 4'hF);
    write_reg(sink_pkg::REG_STRIDE, 32'h0000_3C00, 4'b0010);
    read_reg(sink_pkg::REG_STRIDE, rd);
    check_equal(64'(rd), 64'hA5A5_3CA5, "STRIDE after partial write");
    write_reg(sink_pkg::REG_LEN, 32'h0000_0ABC, 4'hF);
    write_reg(sink_pkg::REG_LEN, 32'hFFFF_FF55, 4'b0001);
    read_reg(sink_pkg::REG_LEN, rd);
    check_equal(64'(rd), 64'h0000_0A55, "LEN after partial write");
    read_reg(32'h0000_0020, rd);
    check_equal(64'(rd), 64'(0), "unmapped register");

    run_job(32'h0000_0100, 32'd8, 6);
    gnt_pct = 70;
    gap_pct = 20;
    for (int unsigned off = 1; off < 4; off++) begin
      run_job(32'h0000_1000 + off, 32'd16, 5);
    end
    gnt_pct = 40; // Heavy back-pressure with gaps in the stream
    gap_pct = 40;
    run_job(32'h0000_2001, 32'd5, 20);
    gnt_pct = 70;
    gap_pct = 10;
    clear_mid_job();
    run_job(32'h0000_0400, 32'd8, 6);

    $display("Checks: %0d, errors: %0d", checks + hold_checks, errors + hold_errors);
    if (errors + hold_errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- hw/sink_top.sv
`timescale 1ns/100ps
`default_nettype none

module sink_top #(
  parameter int unsigned DATA_WIDTH = 64
) (
  input  wire logic                         clk_i,
  input  wire logic                         rst_ni,
  input  wire sink_pkg::addr_t              awaddr_i,
  input  wire logic                         awvalid_i,
  output logic                              awready_o,
  input  wire logic [31:0]                  wdata_i,
  input  wire logic [3:0]                   wstrb_i,
  input  wire logic                         wvalid_i,
  output logic                              wready_o,
  output logic [1:0]                        bresp_o,
  output logic                              bvalid_o,
  input  wire logic                         bready_i,
  input  wire sink_pkg::addr_t              araddr_i,
  input  wire logic                         arvalid_i,
  output logic                              arready_o,
  output logic [31:0]                       rdata_o,
  output logic [1:0]                        rresp_o,
  output logic                              rvalid_o,
  input  wire logic                         rready_i,
  input  wire logic                         stream_valid_i,
  output logic                              stream_ready_o,
  input  wire logic [DATA_WIDTH-33:0]       stream_data_i,
  input  wire logic [(DATA_WIDTH-32)/8-1:0] stream_strb_i,
  output logic                              mem_req_o,
  input  wire logic                         mem_gnt_i,
  output sink_pkg::addr_t                   mem_addr_o,
  output logic [DATA_WIDTH/8-1:0]           mem_be_o,
  output logic [DATA_WIDTH-1:0]             mem_data_o,
  output logic                              done_o
);

  logic            start, clear, ready_start, gen_done;
  sink_pkg::addr_t base, stride;
  sink_pkg::len_t  len;
  sink_pkg::addr_t gen_addr, q_addr;
  logic            gen_valid, gen_ready, q_valid, q_ready;

  sink_regs_axil i_regs (
    .clk_i, .rst_ni,
    .awaddr_i, .awvalid_i, .awready_o, .wdata_i, .wstrb_i, .wvalid_i, .wready_o,
    .bresp_o, .bvalid_o, .bready_i,
    .araddr_i, .arvalid_i, .arready_o, .rdata_o, .rresp_o, .rvalid_o, .rready_i,
    .start_o       ( start       ),
    .clear_o       ( clear       ),
    .base_o        ( base        ),
    .stride_o      ( stride      ),
    .len_o         ( len         ),
    .ready_start_i ( ready_start ),
    .done_i        ( done_o      )
  );

  sink_addrgen i_addrgen (
    .clk_i, .rst_ni,
    .clear_i      ( clear     ),
    .start_i      ( start     ),
    .base_i       ( base      ),
    .stride_i     ( stride    ),
    .len_i        ( len       ),
    .addr_o       ( gen_addr  ),
    .addr_valid_o ( gen_valid ),
    .addr_ready_i ( gen_ready ),
    .done_o       ( gen_done  )
  );

  sink_addr_fifo i_addr_fifo (
    .clk_i, .rst_ni,
    .clear_i      ( clear     ),
    .push_data_i  ( gen_addr  ),
    .push_valid_i ( gen_valid ),
    .push_ready_o ( gen_ready ),
    .pop_data_o   ( q_addr    ),
    .pop_valid_o  ( q_valid   ),
    .pop_ready_i  ( q_ready   )
  );

  sink_streamer #(
    .DATA_WIDTH ( DATA_WIDTH )
  ) i_streamer (
    .clk_i, .rst_ni,
    .clear_i        ( clear       ),
    .start_i        ( start       ),
    .len_i          ( len         ),
    .gen_done_i     ( gen_done    ),
    .addr_i         ( q_addr      ),
    .addr_valid_i   ( q_valid     ),
    .addr_ready_o   ( q_ready     ),
    .stream_valid_i, .stream_ready_o, .stream_data_i, .stream_strb_i,
    .mem_req_o, .mem_gnt_i, .mem_addr_o, .mem_be_o, .mem_data_o,
    .ready_start_o  ( ready_start ),
    .done_o
  );

endmodule

`default_nettype wire

//--- hw/sink_regs_axil.sv
`timescale 1ns/100ps
`default_nettype none

module sink_regs_axil (
  input  wire logic            clk_i,
  input  wire logic            rst_ni,
  input  wire sink_pkg::addr_t awaddr_i,
  input  wire logic            awvalid_i,
  output logic                 awready_o,
  input  wire logic [31:0]     wdata_i,
  input  wire logic [3:0]      wstrb_i,
  input  wire logic            wvalid_i,
  output logic                 wready_o,
  output logic [1:0]           bresp_o,
  output logic                 bvalid_o,
  input  wire logic            bready_i,
  input  wire sink_pkg::addr_t araddr_i,
  input  wire logic            arvalid_i,
  output logic                 arready_o,
  output logic [31:0]          rdata_o,
  output logic [1:0]           rresp_o,
  output logic                 rvalid_o,
  input  wire logic            rready_i,
  output logic                 start_o,
  output logic                 clear_o,
  output sink_pkg::addr_t      base_o,
  output sink_pkg::addr_t      stride_o,
  output sink_pkg::len_t       len_o,
  input  wire logic            ready_start_i,
  input  wire logic            done_i
);

  logic            wready_q;
  logic            bvalid_q;
  logic            arready_q;
  logic            rvalid_q;
  logic [31:0]     rdata_q;
  logic            done_sticky_q;
  logic            wr_en;
  logic            ctrl_wr;
  sink_pkg::addr_t base_q;
  sink_pkg::addr_t stride_q;
  sink_pkg::len_t  len_q;
  logic [31:0]     rd_mux;

  assign awready_o = wready_q; // Address and data are accepted together
  assign wready_o  = wready_q;
  assign bvalid_o  = bvalid_q;
  assign bresp_o   = 2'b00;
  assign arready_o = arready_q;
  assign rvalid_o  = rvalid_q;
  assign rdata_o   = rdata_q;
  assign rresp_o   = 2'b00;

  assign wr_en   = wready_q & awvalid_i & wvalid_i;
  assign ctrl_wr = wr_en & (awaddr_i == sink_pkg::REG_CTRL) & wstrb_i[0];

  // A start outside IDLE never reaches the datapath
  assign start_o = ctrl_wr & wdata_i[0] & ready_start_i;
  assign clear_o = ctrl_wr & wdata_i[1];

  assign base_o   = base_q;
  assign stride_o = stride_q;
  assign len_o    = len_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wready_q <= 1'b0;
      bvalid_q <= 1'b0;
    end else begin
      wready_q <= awvalid_i & wvalid_i & ~wready_q & ~bvalid_q;
      if (wr_en) bvalid_q <= 1'b1;
      else if (bready_i) bvalid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      base_q   <= '0;
      stride_q <= '0;
      len_q    <= '0;
    end else if (wr_en) begin
      for (int b = 0; b < 4; b++) begin
        if (wstrb_i[b]) begin
          if (awaddr_i == sink_pkg::REG_BASE) base_q[8*b +: 8] <= wdata_i[8*b +: 8];
          if (awaddr_i == sink_pkg::REG_STRIDE) stride_q[8*b +: 8] <= wdata_i[8*b +: 8];
          if (awaddr_i == sink_pkg::REG_LEN && b < 2) len_q[8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
    end
  end

  // Done stays visible in STATUS until software starts the next job
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      done_sticky_q <= 1'b0;
    end else if (done_i) begin
      done_sticky_q <= 1'b1;
    end else if (start_o) begin
      done_sticky_q <= 1'b0;
    end
  end

  always_comb begin
    case (araddr_i)
      sink_pkg::REG_STATUS: rd_mux = {30'd0, done_sticky_q, ready_start_i};
      sink_pkg::REG_BASE:   rd_mux = base_q;
      sink_pkg::REG_STRIDE: rd_mux = stride_q;
      sink_pkg::REG_LEN:    rd_mux = {16'd0, len_q};
      default:              rd_mux = 32'd0; // CTRL is write only
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      arready_q <= 1'b0;
      rvalid_q  <= 1'b0;
    end else begin
      arready_q <= arvalid_i & ~arready_q & ~rvalid_q;
      if (arready_q && arvalid_i) rvalid_q <= 1'b1;
      else if (rready_i) rvalid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (arready_q && arvalid_i) rdata_q <= rd_mux;
  end

endmodule

`default_nettype wire

//--- hw/sink_streamer.sv
`timescale 1ns/100ps
`default_nettype none

module sink_streamer #(
  parameter int unsigned DATA_WIDTH = 64
) (
  input  wire logic                       clk_i,
  input  wire logic                       rst_ni,
  input  wire logic                       clear_i,
  input  wire logic                       start_i,
  input  wire sink_pkg::len_t             len_i,
  input  wire logic                       gen_done_i,
  input  wire sink_pkg::addr_t            addr_i,
  input  wire logic                       addr_valid_i,
  output logic                            addr_ready_o,
  input  wire logic                       stream_valid_i,
  output logic                            stream_ready_o,
  input  wire logic [DATA_WIDTH-33:0]     stream_data_i,
  input  wire logic [(DATA_WIDTH-32)/8-1:0] stream_strb_i,
  output logic                            mem_req_o,
  input  wire logic                       mem_gnt_i,
  output sink_pkg::addr_t                 mem_addr_o,
  output logic [DATA_WIDTH/8-1:0]         mem_be_o,
  output logic [DATA_WIDTH-1:0]           mem_data_o,
  output logic                            ready_start_o,
  output logic                            done_o
);

  localparam int unsigned STRB_W = DATA_WIDTH / 8;

  sink_pkg::streamer_state_t cs, ns;
  sink_pkg::len_t            cnt_q;
  logic                      cnt_en;
  logic                      cnt_clr;
  logic                      done;
  logic                      done_q;
  logic                      active;
  logic [1:0]                offset;
  logic [DATA_WIDTH-1:0]     data_ext;
  logic [STRB_W-1:0]         strb_ext;
  logic [DATA_WIDTH-1:0]     data_aligned;
  logic [STRB_W-1:0]         strb_aligned;

  // The beat is zero extended to the bus and moved up by the byte offset of its address
  assign offset       = addr_i[1:0];
  assign data_ext     = DATA_WIDTH'(stream_data_i);
  assign strb_ext     = STRB_W'(stream_strb_i);
  assign data_aligned = data_ext << {offset, 3'b000};
  assign strb_aligned = strb_ext << offset;

  assign active = (cs != sink_pkg::STREAMER_IDLE);

  assign mem_req_o  = active & stream_valid_i & addr_valid_i;
  assign mem_addr_o = active ? {addr_i[sink_pkg::ADDR_W-1:2], 2'b00} : '0;
  assign mem_be_o   = active ? strb_aligned : '0;
  assign mem_data_o = active ? data_aligned : '0;

  // An idle stream is always ready, a real beat waits for grant and an address
  assign stream_ready_o = ~stream_valid_i | (mem_gnt_i & addr_valid_i);
  assign addr_ready_o   = stream_valid_i & stream_ready_o;

  assign cnt_en = addr_valid_i & addr_ready_o; // One count per memory write

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cs <= sink_pkg::STREAMER_IDLE;
    end else if (clear_i) begin
      cs <= sink_pkg::STREAMER_IDLE;
    end else begin
      cs <= ns;
    end
  end

  always_comb begin
    ns            = cs;
    done          = 1'b0;
    cnt_clr       = 1'b0;
    ready_start_o = 1'b0;
    case (cs)
      sink_pkg::STREAMER_IDLE: begin
        ready_start_o = 1'b1;
        if (start_i) ns = sink_pkg::STREAMER_WORKING;
      end
      sink_pkg::STREAMER_WORKING: begin
        if (gen_done_i) ns = sink_pkg::STREAMER_DONE; // All addresses issued
      end
      sink_pkg::STREAMER_DONE: begin
        // Wait until the queued addresses have also been written
        if (cnt_q == len_i) begin
          ns      = sink_pkg::STREAMER_IDLE;
          done    = 1'b1;
          cnt_clr = 1'b1;
        end
      end
      default: ns = sink_pkg::STREAMER_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (clear_i || cnt_clr) begin
      cnt_q <= '0;
    end else if (cnt_en) begin
      cnt_q <= cnt_q + sink_pkg::len_t'(1);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      done_q <= 1'b0;
    end else if (clear_i) begin
      done_q <= 1'b0;
    end else begin
      done_q <= done;
    end
  end

  assign done_o = done_q;

endmodule

`default_nettype wire

//--- hw/sink_addr_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module sink_addr_fifo (
  input  wire logic            clk_i,
  input  wire logic            rst_ni,
  input  wire logic            clear_i,
  input  wire sink_pkg::addr_t push_data_i,
  input  wire logic            push_valid_i,
  output logic                 push_ready_o,
  output sink_pkg::addr_t      pop_data_o,
  output logic                 pop_valid_o,
  input  wire logic            pop_ready_i
);

  sink_pkg::addr_t mem_q [2];
  logic            wr_ptr_q;
  logic            rd_ptr_q;
  logic [1:0]      cnt_q;
  logic            push;
  logic            pop;

  // Both flags come from the occupancy register, so push never reaches pop in the same cycle
  assign push_ready_o = (cnt_q != 2'd2);
  assign pop_valid_o  = (cnt_q != 2'd0);
  assign pop_data_o   = mem_q[rd_ptr_q];

  assign push = push_valid_i & push_ready_o;
  assign pop  = pop_valid_o & pop_ready_i;

  always_ff @(posedge clk_i) begin
    if (push) mem_q[wr_ptr_q] <= push_data_i;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      cnt_q    <= 2'd0;
    end else if (clear_i) begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      cnt_q    <= 2'd0;
    end else begin
      if (push) wr_ptr_q <= ~wr_ptr_q;
      if (pop) rd_ptr_q <= ~rd_ptr_q;
      if (push && !pop) cnt_q <= cnt_q + 2'd1;
      else if (pop && !push) cnt_q <= cnt_q - 2'd1;
    end
  end

endmodule

`default_nettype wire

//--- hw/sink_addrgen.sv
`timescale 1ns/100ps
`default_nettype none

module sink_addrgen (
  input  wire logic           clk_i,
  input  wire logic           rst_ni,
  input  wire logic           clear_i,
  input  wire logic           start_i,
  input  wire sink_pkg::addr_t base_i,
  input  wire sink_pkg::addr_t stride_i,
  input  wire sink_pkg::len_t  len_i,
  output sink_pkg::addr_t     addr_o,
  output logic                addr_valid_o,
  input  wire logic           addr_ready_i,
  output logic                done_o
);

  sink_pkg::addr_t addr_q;
  sink_pkg::addr_t stride_q;
  sink_pkg::len_t  len_q;
  sink_pkg::len_t  cnt_q;
  logic            active_q;
  logic            done_q;
  logic            handshake;

  assign handshake = active_q & addr_ready_i;
  assign addr_o       = addr_q;
  assign addr_valid_o = active_q;
  assign done_o       = done_q;

  // Job parameters are sampled at start so the register file may change under us
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr_q   <= '0;
      stride_q <= '0;
      len_q    <= '0;
      cnt_q    <= '0;
      active_q <= 1'b0;
      done_q   <= 1'b0;
    end else if (clear_i) begin
      addr_q   <= '0;
      stride_q <= '0;
      len_q    <= '0;
      cnt_q    <= '0;
      active_q <= 1'b0;
      done_q   <= 1'b0;
    end else if (start_i) begin
      addr_q   <= base_i; // Presample the first address
      stride_q <= stride_i;
      len_q    <= len_i;
      cnt_q    <= '0;
      active_q <= 1'b1;
      done_q   <= 1'b0;
    end else if (handshake) begin
      addr_q <= addr_q + stride_q;
      cnt_q  <= cnt_q + sink_pkg::len_t'(1);
      if (cnt_q == len_q - sink_pkg::len_t'(1)) begin
        active_q <= 1'b0; // Last address has left
        done_q   <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- hw/sink_pkg.sv
`default_nettype none

package sink_pkg;

  // Byte address width on both the configuration and memory side
  localparam int unsigned ADDR_W = 32;

  typedef logic [ADDR_W-1:0] addr_t;

  // Beat count, also used as the width of the transfer counter
  typedef logic [15:0] len_t;

  typedef enum logic [1:0] {
    STREAMER_IDLE,
    STREAMER_WORKING,
    STREAMER_DONE
  } streamer_state_t;

  // Register map of the configuration port, byte offsets
  localparam addr_t REG_CTRL   = 32'h0000_0000; // Bit 0 start, bit 1 clear
  localparam addr_t REG_STATUS = 32'h0000_0004; // Bit 0 ready for start, bit 1 done
  localparam addr_t REG_BASE   = 32'h0000_0008;
  localparam addr_t REG_STRIDE = 32'h0000_000C;
  localparam addr_t REG_LEN    = 32'h0000_0010;

endpackage

`default_nettype wire
